/* Bender.yml */
package:
  name: zx_ula_video

sources:
  - ula_pkg.sv
  - raster_counter.sv
  - screen_fetch.sv
  - pixel_shifter.sv
  - frame_irq.sv
  - zx_ula_video.sv
  - target: test
    files:
      - tb_zx_ula_video.sv

/* frame_irq.sv */
`default_nettype none

module frame_irq import ula_pkg::*; (
	input  wire              clk14,
	input  wire              rst_n,
	input  wire  [HC_W-1:0]  hc,
	input  wire  [VC_W-1:0]  vc,
	input  timing_mode_t     mode,
	output logic             n_int,
	output logic             frame_tick
);

	logic int_win;

	always_comb begin
		if (mode == TIMING_S128)
			int_win = (vc == VC_W'(INT_V_S128)) && (hc >= HC_W'(INT_H_FROM_S128)) &&
				(hc <= HC_W'(INT_H_TO_S128));
		else
			int_win = (vc == VC_W'(INT_V_PENT)) && (hc >= HC_W'(INT_H_FROM_PENT)) &&
				(hc <= HC_W'(INT_H_TO_PENT));
	end

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			n_int <= 1'b1;
			frame_tick <= 1'b0;
		end else begin
			n_int <= ~int_win;
			// one pulse as n_int falls
			frame_tick <= int_win & n_int;
		end
	end

endmodule

`default_nettype wire

/* pixel_shifter.sv */
`default_nettype none

module pixel_shifter import ula_pkg::*; #(
	parameter int FLASH_DIV_LOG2 = 4
) (
	input  wire              clk14,
	input  wire              rst_n,
	input  wire              pix_phase,
	input  wire  [HC_W-1:0]  hc,
	input  wire  [VC_W-1:0]  vc,
	input  wire              hsync_raw,
	input  wire              vsync_raw,
	input  wire              blank_raw,
	input  wire  [7:0]       bitmap_next,
	input  wire  [7:0]       attr_next,
	input  wire              screen_update,
	input  wire              frame_tick,
	input  wire              border_wr,
	input  wire  [2:0]       border,
	output logic             r,
	output logic             g,
	output logic             b,
	output logic             i,
	output logic             hsync,
	output logic             vsync,
	output logic             csync
);

	logic [2:0] border_q;
	logic [FLASH_DIV_LOG2:0] flash_cnt;
	logic flash;
	logic [7:0] bitmap;
	logic [7:0] attr;
	logic show;
	logic ink;
	logic [2:0] grb;

	assign flash = flash_cnt[FLASH_DIV_LOG2];

	// column x of the screen is on the output while hc is x + SCREEN_DELAY
	assign show = (vc < VC_W'(V_AREA)) && (hc >= HC_W'(SCREEN_DELAY)) &&
		(hc < HC_W'(H_AREA + SCREEN_DELAY));

	assign ink = bitmap[7] ^ (attr[7] & flash);
	assign grb = ink ? attr[2:0] : attr[5:3];

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			border_q <= '0;
			flash_cnt <= '0;
		end else begin
			if (border_wr)
				border_q <= border;
			if (frame_tick)
				flash_cnt <= flash_cnt + 1'b1;
		end
	end

	// in the border the paper colour is the border and no pixel is set
	always_ff @(posedge clk14) begin
		if (!show) begin
			attr <= {2'b00, border_q, 3'b000};
			bitmap <= 8'h00;
		end else if (screen_update) begin
			attr <= attr_next;
			bitmap <= bitmap_next;
		end else if (pix_phase) begin
			bitmap <= {bitmap[6:0], 1'b0};
		end
	end

	// outputs move once per pixel, at the end of its second half
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			{g, r, b, i} <= 4'b0000;
			hsync <= 1'b1;
			vsync <= 1'b1;
			csync <= 1'b1;
		end else if (pix_phase) begin
			if (blank_raw) begin
				{g, r, b, i} <= 4'b0000;
			end else begin
				{g, r, b} <= grb;
				// bright has no effect on black
				i <= attr[6] & (|grb);
			end
			hsync <= ~hsync_raw;
			vsync <= ~vsync_raw;
			csync <= ~(hsync_raw ^ vsync_raw);
		end
	end

endmodule

`default_nettype wire

/* raster_counter.sv */
`default_nettype none

module raster_counter import ula_pkg::*; (
	input  wire               clk14,
	input  wire               rst_n,
	input  timing_mode_t      mode,
	output logic [HC_W-1:0]   hc,
	output logic [VC_W-1:0]   vc,
	output logic              pix_phase,
	output logic              frame_end,
	output logic              hsync_raw,
	output logic              vsync_raw,
	output logic              blank_raw
);

	timing_mode_t mode_q;
	logic [HC_W-1:0] h_last;
	logic [VC_W-1:0] v_last;
	logic [HC_W-1:0] hsync_from;
	logic [HC_W-1:0] hsync_to;
	logic [HC_W-1:0] hblank_from;
	logic [HC_W-1:0] hblank_to;
	logic [VC_W-1:0] vsync_from;
	logic [VC_W-1:0] vsync_to;
	logic line_end;

	// window edges of the latched timing
	always_comb begin
		if (mode_q == TIMING_S128) begin
			h_last      = HC_W'(H_TOTAL_S128 - 1);
			v_last      = VC_W'(V_TOTAL_S128 - 1);
			hblank_from = HC_W'(H_AREA + H_RBORDER_S128);
			hsync_from  = HC_W'(H_AREA + H_RBORDER_S128 + H_BLANK1_S128);
			hsync_to    = HC_W'(H_AREA + H_RBORDER_S128 + H_BLANK1_S128 + H_SYNC_S128);
			hblank_to   = HC_W'(H_AREA + H_RBORDER_S128 + H_BLANK1_S128 + H_SYNC_S128 +
				H_BLANK2_S128);
			vsync_from  = VC_W'(V_AREA + V_BBORDER_S128);
			vsync_to    = VC_W'(V_AREA + V_BBORDER_S128 + V_SYNC_S128);
		end else begin
			h_last      = HC_W'(H_TOTAL_PENT - 1);
			v_last      = VC_W'(V_TOTAL_PENT - 1);
			hblank_from = HC_W'(H_AREA + H_RBORDER_PENT);
			hsync_from  = HC_W'(H_AREA + H_RBORDER_PENT + H_BLANK1_PENT);
			hsync_to    = HC_W'(H_AREA + H_RBORDER_PENT + H_BLANK1_PENT + H_SYNC_PENT);
			hblank_to   = HC_W'(H_AREA + H_RBORDER_PENT + H_BLANK1_PENT + H_SYNC_PENT +
				H_BLANK2_PENT);
			vsync_from  = VC_W'(V_AREA + V_BBORDER_PENT);
			vsync_to    = VC_W'(V_AREA + V_BBORDER_PENT + V_SYNC_PENT);
		end
	end

	assign line_end  = pix_phase && (hc == h_last);
	assign frame_end = line_end && (vc == v_last);

	assign hsync_raw = (hc >= hsync_from) && (hc < hsync_to);
	assign vsync_raw = (vc >= vsync_from) && (vc < vsync_to);
	// vertical blank covers only the sync lines
	assign blank_raw = vsync_raw || ((hc >= hblank_from) && (hc < hblank_to));

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			pix_phase <= 1'b0;
			hc <= '0;
			vc <= '0;
			mode_q <= TIMING_S128;
		end else begin
			pix_phase <= ~pix_phase;
			if (line_end) begin
				hc <= '0;
				if (frame_end) begin
					vc <= '0;
					// new timing takes effect on a whole frame only
					mode_q <= mode;
				end else begin
					vc <= vc + 1'b1;
				end
			end else if (pix_phase) begin
				hc <= hc + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* screen_fetch.sv */
`default_nettype none

module screen_fetch import ula_pkg::*; (
	input  wire                    clk14,
	input  wire                    rst_n,
	input  wire  [HC_W-1:0]        hc,
	input  wire  [VC_W-1:0]        vc,
	input  wire                    pix_phase,
	input  wire                    frame_end,
	input  wire  [7:0]             vram_data,
	output logic                   vram_rd,
	output logic [SCR_ADDR_W-1:0]  vram_addr,
	output logic [7:0]             bitmap_next,
	output logic [7:0]             attr_next,
	output logic                   screen_update
);

	logic load;
	logic rd_attr_q;
	logic rd_bitmap_q;
	logic [SCR_ADDR_W-1:0] bitmap_addr;
	logic [SCR_ADDR_W-1:0] attr_addr;

	assign load = (vc < VC_W'(V_AREA)) && (hc < HC_W'(H_AREA));

	// third, line within char and char row are swapped in the bitmap
	assign bitmap_addr = {2'b00, vc[7:6], vc[2:0], vc[5:3], hc[7:3]};
	// attributes start at 0x1800, 32 bytes per char row
	assign attr_addr = {2'b00, 3'b110, vc[7:3], hc[7:3]};

	// strobe and address are registered, so the phase seen outside is the
	// opposite of the one they were built in
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			vram_rd <= 1'b0;
			rd_attr_q <= 1'b0;
			rd_bitmap_q <= 1'b0;
			screen_update <= 1'b0;
		end else begin
			vram_rd <= load;
			if (frame_end) begin
				rd_attr_q <= 1'b0;
				rd_bitmap_q <= 1'b0;
			end else begin
				rd_attr_q <= vram_rd && !pix_phase;
				rd_bitmap_q <= vram_rd && pix_phase;
			end
			// lands on the even half of pixels 8, 16 .. 256
			screen_update <= load && pix_phase && (hc[2:0] == 3'd7);
		end
	end

	always_ff @(posedge clk14) begin
		vram_addr <= pix_phase ? attr_addr : bitmap_addr;
	end

	// data comes back one cycle after the strobe
	always_ff @(posedge clk14) begin
		if (rd_bitmap_q)
			bitmap_next <= vram_data;

		if (rd_attr_q)
			attr_next <= vram_data;
		else if (!load)
			attr_next <= 8'hff;
	end

endmodule

`default_nettype wire

/* tb_zx_ula_video.sv */
`default_nettype none

module tb_zx_ula_video import ula_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEL_HSYNC = 0;
	localparam int SEL_VSYNC = 1;
	localparam int SEL_NINT = 2;
	localparam int SEL_RD = 3;
	localparam int LINE_S128 = 2 * H_TOTAL_S128;
	localparam int FRAME_PENT = 2 * H_TOTAL_PENT * V_TOTAL_PENT;
	localparam int WAIT_LINE = LINE_S128 + 16;
	localparam int WAIT_FRAME = FRAME_PENT + LINE_S128;
	localparam int HBLANK_END = H_AREA + H_RBORDER_S128 + H_BLANK1_S128 + H_SYNC_S128 +
		H_BLANK2_S128;

	logic clk14;
	logic rst_n;
	timing_mode_t mode;
	logic border_wr;
	logic [2:0] border;
	logic vram_rd;
	logic [SCR_ADDR_W-1:0] vram_addr;
	logic [7:0] vram_data;
	logic r, g, b, i;
	logic hsync, vsync, csync, n_int;
	logic [7:0] vram [0:16383];
	longint cyc = 0;
	int int_count = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed = 0;
	bit timed_out = 0;
	int unsigned seed_val;
	int a;

	zx_ula_video #(
		.FLASH_DIV_LOG2 (1)
	) uut (
		.clk14 (clk14), .rst_n (rst_n), .mode (mode),
		.border_wr (border_wr), .border (border),
		.vram_rd (vram_rd), .vram_addr (vram_addr), .vram_data (vram_data),
		.r (r), .g (g), .b (b), .i (i),
		.hsync (hsync), .vsync (vsync), .csync (csync), .n_int (n_int)
	);

	initial begin
		clk14 = 1'b0;
		forever #10 clk14 = ~clk14;
	end

	always @(posedge clk14) cyc <= cyc + 1;

	// frame interrupts since reset, the flash counter steps on each one
	always @(negedge n_int) int_count <= int_count + 1;

	// screen memory, data one cycle after the strobe
	always @(posedge clk14) begin
		if (vram_rd)
			vram_data <= vram[vram_addr[13:0]];
	end

	function automatic logic probe(input int sel);
		case (sel)
			SEL_HSYNC: return hsync;
			SEL_VSYNC: return vsync;
			SEL_NINT: return n_int;
			default: return vram_rd;
		endcase
	endfunction

	// expected output for one pixel, bright is dropped on black
	function automatic logic [3:0] pixel(input logic [2:0] grb, input logic bright);
		return {grb, bright & (|grb)};
	endfunction

	function automatic logic [7:0] random_attr(input logic flash);
		logic [31:0] rnd;
		logic [2:0] ink;
		logic [2:0] paper;
		rnd = $urandom;
		ink = rnd[2:0];
		// paper always differs from ink
		paper = ink ^ ((rnd[5:3] == 3'd0) ? 3'd1 : rnd[5:3]);
		return {flash, rnd[6], paper, ink};
	endfunction

	task automatic check_value(input string name, input longint exp, input longint act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// samples on the falling clock edge, returns the cycle of the transition
	task automatic wait_edge(input int sel, input logic level, input int limit,
		input string what, output longint at);
		logic prev;
		int n;
		at = 0;
		if (timed_out)
			return;
		prev = probe(sel);
		for (n = 0; n < limit; n++) begin
			@(negedge clk14);
			if (probe(sel) == level && prev != level) begin
				at = cyc;
				return;
			end
			prev = probe(sel);
		end
		timed_out = 1;
		errors++;
		$display("timeout while waiting for %s", what);
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("PASS %s", name);
		end else begin
			failed++;
			$display("FAIL %s", name);
		end
	endtask

	// first read of screen line 0 in the next frame
	task automatic find_line0(output longint t0);
		longint t;
		wait_edge(SEL_VSYNC, 1'b1, WAIT_FRAME, "vsync to rise", t);
		wait_edge(SEL_RD, 1'b1, WAIT_FRAME, "the first screen read", t0);
	endtask

	task automatic fill_screen(input logic [7:0] bitmap, input logic [7:0] attr);
		int k;
		for (k = 0; k < 16'h1b00; k++)
			vram[k] = (k < 16'h1800) ? bitmap : attr;
	endtask

	task automatic test_frame_timing(input string name, input int h_total, input int v_total,
		input int skip);
		longint t0, t1;
		int err0;
		err0 = errors;
		repeat (skip) wait_edge(SEL_VSYNC, 1'b1, WAIT_FRAME, "vsync to rise", t0);
		wait_edge(SEL_HSYNC, 1'b1, WAIT_LINE, "hsync to rise", t0);
		wait_edge(SEL_HSYNC, 1'b1, WAIT_LINE, "hsync to rise", t1);
		check_value({name, " line"}, 2 * h_total, t1 - t0);
		wait_edge(SEL_VSYNC, 1'b1, WAIT_FRAME, "vsync to rise", t0);
		wait_edge(SEL_VSYNC, 1'b1, WAIT_FRAME, "vsync to rise", t1);
		check_value({name, " frame"}, 2 * h_total * v_total, t1 - t0);
		finish_test(name, err0);
	endtask

	task automatic test_irq(input string name, input int low, input int frame);
		longint t_fall, t_rise, t_next;
		int err0;
		err0 = errors;
		wait_edge(SEL_NINT, 1'b0, WAIT_FRAME, "n_int to fall", t_fall);
		wait_edge(SEL_NINT, 1'b1, WAIT_LINE, "n_int to rise", t_rise);
		check_value({name, " low time"}, low, t_rise - t_fall);
		wait_edge(SEL_NINT, 1'b0, WAIT_FRAME, "n_int to fall", t_next);
		check_value({name, " period"}, frame, t_next - t_fall);
		finish_test(name, err0);
	endtask

	task automatic test_addresses();
		longint t0;
		int err0, n, l;
		logic [7:0] line;
		logic [4:0] k;
		logic [SCR_ADDR_W-1:0] exp;
		err0 = errors;
		find_line0(t0);
		for (l = 0; l <= 9; l++) begin
			if (l > 0)
				wait_edge(SEL_RD, 1'b1, WAIT_LINE, "a screen read", t0);
			line = l;
			n = 0;
			// bitmap and attribute reads alternate, two per pixel
			while (vram_rd && n < 4 * H_AREA) begin
				k = n / 16;
				if (n % 2 == 0)
					exp = {2'b00, line[7:6], line[2:0], line[5:3], k};
				else
					exp = 15'h1800 + line[7:3] * 32 + k;
				if (l == 0 || l == 9)
					check_value("screen addresses", exp, vram_addr);
				n++;
				@(negedge clk14);
			end
			check_value("screen addresses, reads per line", 2 * H_AREA, n);
		end
		finish_test("screen addresses", err0);
	endtask

	task automatic test_pixels();
		logic [7:0] attr;
		logic [3:0] exp;
		longint t0;
		int err0, x;
		err0 = errors;
		attr = random_attr(1'b0);
		fill_screen(8'hf0, attr);
		find_line0(t0);
		// column x is on the output 2 * (x + SCREEN_DELAY) + 1 cycles after the first read
		repeat (2 * SCREEN_DELAY + 1) @(negedge clk14);
		for (x = 0; x < H_AREA; x++) begin
			if (x % 8 < 4)
				exp = pixel(attr[2:0], attr[6]);
			else
				exp = pixel(attr[5:3], attr[6]);
			check_value("ink and paper", exp, {g, r, b, i});
			repeat (2) @(negedge clk14);
		end
		finish_test("ink and paper", err0);
	endtask

	task automatic test_border();
		logic [31:0] rnd;
		logic [2:0] colour;
		longint t0;
		int err0, o, h;
		err0 = errors;
		rnd = $urandom;
		colour = (rnd[2:0] == 3'd0) ? 3'd5 : rnd[2:0];
		@(posedge clk14);
		border_wr <= 1'b1;
		border <= colour;
		@(posedge clk14);
		border_wr <= 1'b0;
		find_line0(t0);
		// h is the pixel counter of the output, one pixel behind the raster
		for (o = 1; o <= 2 * HBLANK_END; o++) begin
			@(negedge clk14);
			h = (o + 1) / 2;
			if (h <= SCREEN_DELAY || (h > H_AREA + SCREEN_DELAY && h <= H_AREA + H_RBORDER_S128))
				check_value("border colour", {colour, 1'b0}, {g, r, b, i});
			else if (h > H_AREA + H_RBORDER_S128)
				check_value("blank colour", 0, {g, r, b, i});
			check_value("composite sync", !(hsync ^ vsync), csync);
		end
		finish_test("border and blank", err0);
	endtask

	task automatic test_flash();
		logic [7:0] attr;
		logic [3:0] ink_px, paper_px;
		logic [3:0] col0 [0:2];
		logic [3:0] col4 [0:2];
		logic swapped [0:2];
		longint t0;
		int err0, f;
		err0 = errors;
		attr = random_attr(1'b1);
		fill_screen(8'hf0, attr);
		ink_px = pixel(attr[2:0], attr[6]);
		paper_px = pixel(attr[5:3], attr[6]);
		for (f = 0; f < 3; f++) begin
			find_line0(t0);
			repeat (2 * SCREEN_DELAY + 1) @(negedge clk14);
			col0[f] = {g, r, b, i};
			// flash phase is bit 1 of the interrupt count, so it flips every two frames
			swapped[f] = int_count[1];
			repeat (8) @(negedge clk14);
			col4[f] = {g, r, b, i};
		end
		for (f = 0; f < 3; f++) begin
			check_value("flash column 0", swapped[f] ? paper_px : ink_px, col0[f]);
			check_value("flash column 4", swapped[f] ? ink_px : paper_px, col4[f]);
		end
		finish_test("flash", err0);
	endtask

	initial begin
		rst_n = 1'b0;
		mode = TIMING_S128;
		border_wr = 1'b0;
		border = 3'd0;
		vram_data = 8'h00;
		seed_val = $urandom(32'h8994);
		for (a = 0; a < 16384; a++)
			vram[a] = a[7:0] ^ a[15:8];
		repeat (5) @(posedge clk14);
		rst_n <= 1'b1;

		test_frame_timing("S128 frame timing", 456, 311, 0);
		test_irq("S128 interrupt", 128, 912 * 311);
		test_addresses();
		test_pixels();
		test_border();
		test_flash();

		@(posedge clk14);
		mode <= TIMING_PENT;
		test_frame_timing("Pentagon frame timing", 448, 320, 2);
		test_irq("Pentagon interrupt", 146, 896 * 320);

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* ula_pkg.sv */
`default_nettype none

package ula_pkg;

	// frame timing selected by the mode input
	typedef enum logic [0:0] {
		TIMING_PENT = 1'b0,
		TIMING_S128 = 1'b1
	} timing_mode_t;

	// visible screen area
	localparam int H_AREA       = 256;
	localparam int V_AREA       = 192;
	// shifter lag behind the fetch, in pixels
	localparam int SCREEN_DELAY = 8;

	// 128K frame, in pixels and lines
	localparam int H_RBORDER_S128 = 48 + SCREEN_DELAY;
	localparam int H_BLANK1_S128  = 28;
	localparam int H_SYNC_S128    = 33;
	localparam int H_BLANK2_S128  = 43;
	localparam int H_LBORDER_S128 = 48 - SCREEN_DELAY;
	localparam int V_BBORDER_S128 = 56;
	localparam int V_SYNC_S128    = 8;
	localparam int V_TBORDER_S128 = 55;
	localparam int H_TOTAL_S128   = H_AREA + H_RBORDER_S128 + H_BLANK1_S128 + H_SYNC_S128 +
		H_BLANK2_S128 + H_LBORDER_S128;
	localparam int V_TOTAL_S128   = V_AREA + V_BBORDER_S128 + V_SYNC_S128 + V_TBORDER_S128;

	// pentagon frame
	localparam int H_RBORDER_PENT = 56 + SCREEN_DELAY;
	localparam int H_BLANK1_PENT  = 8;
	localparam int H_SYNC_PENT    = 33;
	localparam int H_BLANK2_PENT  = 23;
	localparam int H_LBORDER_PENT = 72 - SCREEN_DELAY;
	localparam int V_BBORDER_PENT = 56;
	localparam int V_SYNC_PENT    = 8;
	localparam int V_TBORDER_PENT = 64;
	localparam int H_TOTAL_PENT   = H_AREA + H_RBORDER_PENT + H_BLANK1_PENT + H_SYNC_PENT +
		H_BLANK2_PENT + H_LBORDER_PENT;
	localparam int V_TOTAL_PENT   = V_AREA + V_BBORDER_PENT + V_SYNC_PENT + V_TBORDER_PENT;

	// interrupt position, line and pixel range
	localparam int INT_V_S128      = 248;
	localparam int INT_H_FROM_S128 = 2;
	localparam int INT_H_TO_S128   = 65;
	localparam int INT_V_PENT      = 239;
	localparam int INT_H_FROM_PENT = 336;
	localparam int INT_H_TO_PENT   = 408;

	localparam int HC_W       = 9;
	localparam int VC_W       = 9;
	localparam int SCR_ADDR_W = 15;

endpackage

`default_nettype wire

/* zx_ula_video.f */
ula_pkg.sv
raster_counter.sv
screen_fetch.sv
pixel_shifter.sv
frame_irq.sv
zx_ula_video.sv
tb_zx_ula_video.sv

/* zx_ula_video.sv */
`default_nettype none

module zx_ula_video import ula_pkg::*; #(
	parameter int FLASH_DIV_LOG2 = 4
) (
	input  wire                    clk14,
	input  wire                    rst_n,
	input  timing_mode_t           mode,
	input  wire                    border_wr,
	input  wire  [2:0]             border,
	output logic                   vram_rd,
	output logic [SCR_ADDR_W-1:0]  vram_addr,
	input  wire  [7:0]             vram_data,
	output logic                   r,
	output logic                   g,
	output logic                   b,
	output logic                   i,
	output logic                   hsync,
	output logic                   vsync,
	output logic                   csync,
	output logic                   n_int
);

	logic [HC_W-1:0] hc;
	logic [VC_W-1:0] vc;
	logic pix_phase;
	logic frame_end;
	logic hsync_raw;
	logic vsync_raw;
	logic blank_raw;
	logic [7:0] bitmap_next;
	logic [7:0] attr_next;
	logic screen_update;
	logic frame_tick;

	raster_counter u_raster (
		.clk14     (clk14),
		.rst_n     (rst_n),
		.mode      (mode),
		.hc        (hc),
		.vc        (vc),
		.pix_phase (pix_phase),
		.frame_end (frame_end),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw),
		.blank_raw (blank_raw)
	);

	screen_fetch u_fetch (
		.clk14         (clk14),
		.rst_n         (rst_n),
		.hc            (hc),
		.vc            (vc),
		.pix_phase     (pix_phase),
		.frame_end     (frame_end),
		.vram_data     (vram_data),
		.vram_rd       (vram_rd),
		.vram_addr     (vram_addr),
		.bitmap_next   (bitmap_next),
		.attr_next     (attr_next),
		.screen_update (screen_update)
	);

	pixel_shifter #(
		.FLASH_DIV_LOG2 (FLASH_DIV_LOG2)
	) u_shifter (
		.clk14         (clk14),
		.rst_n         (rst_n),
		.pix_phase     (pix_phase),
		.hc            (hc),
		.vc            (vc),
		.hsync_raw     (hsync_raw),
		.vsync_raw     (vsync_raw),
		.blank_raw     (blank_raw),
		.bitmap_next   (bitmap_next),
		.attr_next     (attr_next),
		.screen_update (screen_update),
		.frame_tick    (frame_tick),
		.border_wr     (border_wr),
		.border        (border),
		.r             (r),
		.g             (g),
		.b             (b),
		.i             (i),
		.hsync         (hsync),
		.vsync         (vsync),
		.csync         (csync)
	);

	frame_irq u_irq (
		.clk14      (clk14),
		.rst_n      (rst_n),
		.hc         (hc),
		.vc         (vc),
		.mode       (mode),
		.n_int      (n_int),
		.frame_tick (frame_tick)
	);

endmodule

`default_nettype wire
